//--- rtl/loop_defs.svh
`ifndef LOOP_DEFS_SVH
`define LOOP_DEFS_SVH

// Word loopback sizing

// Width of one transferred word
`define LOOP_WORD_W 32

// Store entries, head register included
`define LOOP_DEPTH 126

// Slot index width
`define LOOP_IDX_W 7

// Occupancy width, holds 0 to 126
`define LOOP_CNT_W 7

`endif

//--- rtl/loop_buf_pkg.sv
`include "loop_defs.svh"

// Types passed between the fetch, store and issue stages
package loop_buf_pkg;

	////////////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////////////

	// One data word as moved through the loopback
	typedef logic [`LOOP_WORD_W-1:0] word_t;

	////////////////////////////////////////////////////////////////////
	// Store bookkeeping
	////////////////////////////////////////////////////////////////////

	// Slot index into the circular store
	typedef logic [`LOOP_IDX_W-1:0] idx_t;

	// Number of words held in the store
	typedef logic [`LOOP_CNT_W-1:0] cnt_t;

endpackage

//--- rtl/hps_port_pkg.sv
// Bundles for the two host FIFO ports
package hps_port_pkg;

	import loop_buf_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Host to FPGA FIFO, read side
	////////////////////////////////////////////////////////////////////

	// Inputs from the source FIFO
	// Readdata is valid the cycle after a read strobe
	typedef struct packed {
		word_t readdata;
		logic  empty;
	} src_port_t;

	////////////////////////////////////////////////////////////////////
	// FPGA to host FIFO, write side
	////////////////////////////////////////////////////////////////////

	// Outputs to the sink FIFO
	// Write is a one cycle strobe with the word alongside
	typedef struct packed {
		word_t writedata;
		logic  write;
	} sink_port_t;

endpackage

//--- rtl/hps_fifo_fetch.sv
module hps_fifo_fetch
	import loop_buf_pkg::*, hps_port_pkg::*;
(
	input  logic      CLOCK_50,
	input  logic      rst_n,
	input  src_port_t src,
	input  logic      fetch_ready,
	output logic      src_read,
	output word_t     fetch_word,
	output logic      fetch_valid
);

	// Idle, read in flight, word held
	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_hold
	} fetch_st_t;

	fetch_st_t state;
	logic      armed;
	logic      take;

	////////////////////////////////////////////////////////////////////
	// Read strobe
	////////////////////////////////////////////////////////////////////

	// Holding register drains into the store
	assign take = fetch_valid && fetch_ready;

	// Read when nothing held or the held word leaves now
	// Never while a read is in flight
	assign src_read = armed && !src.empty &&
		((state == st_idle) || ((state == st_hold) && fetch_ready));

	assign fetch_valid = (state == st_hold);

	////////////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			armed <= 1'b0;
		end
		else
		begin
			// First cycle out of reset stays quiet
			armed <= 1'b1;
			case (state)
				st_idle:
					if (src_read)
						state <= st_read;
				// Data shows up now, captured below
				st_read:
					state <= st_hold;
				st_hold:
					if (take)
						state <= src_read ? st_read : st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// Holding register for the returned word
	always_ff @(posedge CLOCK_50)
	begin
		if (state == st_read)
			fetch_word <= src.readdata;
	end

endmodule

//--- rtl/loop_store.sv
`include "loop_defs.svh"

module loop_store
	import loop_buf_pkg::*;
(
	input  logic  CLOCK_50,
	input  logic  rst_n,
	input  word_t in_word,
	input  logic  in_valid,
	input  logic  head_ready,
	output logic  in_ready,
	output word_t head_word,
	output logic  head_valid
);

	// Circular word memory
	word_t mem [0:`LOOP_DEPTH-1];

	idx_t wr_ptr;
	idx_t rd_ptr;
	// Words held, head register included
	cnt_t count;

	logic push;
	logic pop_head;
	logic head_free;
	logic mem_has;
	logic load_mem;
	logic load_in;

	// Advance a slot index, last slot wraps to zero
	function automatic idx_t next_idx(input idx_t idx);
		idx_t nxt;
		if (idx == idx_t'(`LOOP_DEPTH - 1))
			nxt = '0;
		else
			nxt = idx + idx_t'(1);
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Handshake decode
	////////////////////////////////////////////////////////////////////

	assign in_ready  = (count != cnt_t'(`LOOP_DEPTH));
	assign push      = in_valid && in_ready;
	assign pop_head  = head_valid && head_ready;
	// Head register open this cycle
	assign head_free = !head_valid || head_ready;
	// Memory holds words beyond the head
	assign mem_has   = (count != cnt_t'(head_valid));
	// Refill head from memory first
	assign load_mem  = head_free && mem_has;
	// Empty memory so the incoming word goes straight to the head
	assign load_in   = head_free && !mem_has && push;

	////////////////////////////////////////////////////////////////////
	// Pointers, count, head flag
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			head_valid <= 1'b0;
		end
		else
		begin
			if (push && !load_in)
				wr_ptr <= next_idx(wr_ptr);
			if (load_mem)
				rd_ptr <= next_idx(rd_ptr);
			// Push and pop may land together
			count <= count + cnt_t'(push) - cnt_t'(pop_head);
			if (load_mem || load_in)
				head_valid <= 1'b1;
			else if (pop_head)
				head_valid <= 1'b0;
		end
	end

	// Memory write and show-ahead head word
	always_ff @(posedge CLOCK_50)
	begin
		if (push && !load_in)
			mem[wr_ptr] <= in_word;
		if (load_mem)
			head_word <= mem[rd_ptr];
		else if (load_in)
			head_word <= in_word;
	end

endmodule

//--- rtl/hps_fifo_issue.sv
module hps_fifo_issue
	import loop_buf_pkg::*, hps_port_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst_n,
	input  word_t      head_word,
	input  logic       head_valid,
	input  logic       sink_full,
	output logic       head_ready,
	output sink_port_t sink
);

	// Register empty, word loaded, idle cycle after a write
	typedef enum logic [1:0] {
		st_empty,
		st_loaded,
		st_settle
	} issue_st_t;

	issue_st_t state;
	word_t     out_word;
	logic      fire;

	////////////////////////////////////////////////////////////////////
	// Output strobe
	////////////////////////////////////////////////////////////////////

	// Take a word only into an empty register
	// Register is empty again once its word is written
	assign head_ready = (state == st_empty) || (state == st_settle);

	// Write as soon as the sink has room
	assign fire = (state == st_loaded) && !sink_full;

	always_comb
	begin
		sink.writedata = out_word;
		sink.write     = fire;
	end

	////////////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
			state <= st_empty;
		else
		begin
			case (state)
				st_empty:
					if (head_valid)
						state <= st_loaded;
				// Hold the word through full cycles
				st_loaded:
					if (fire)
						state <= st_settle;
				// Full flag catches up while the next word loads
				st_settle:
					state <= head_valid ? st_loaded : st_empty;
				default:
					state <= st_empty;
			endcase
		end
	end

	// Output word register
	always_ff @(posedge CLOCK_50)
	begin
		if (head_valid && head_ready)
			out_word <= head_word;
	end

endmodule

//--- rtl/fifo_loopback_top.sv
module fifo_loopback_top
	import loop_buf_pkg::*, hps_port_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst_n,
	input  src_port_t  src,
	input  logic       sink_full,
	output logic       src_read,
	output sink_port_t sink
);

	// Fetch to store link
	word_t fetch_word;
	logic  fetch_valid;
	logic  fetch_ready;

	// Store to issue link
	word_t head_word;
	logic  head_valid;
	logic  head_ready;

	////////////////////////////////////////////////////////////////////
	// Host to FPGA side
	////////////////////////////////////////////////////////////////////

	hps_fifo_fetch u_fetch (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.src         (src),
		.fetch_ready (fetch_ready),
		.src_read    (src_read),
		.fetch_word  (fetch_word),
		.fetch_valid (fetch_valid)
	);

	// Circular store between the ports
	loop_store u_store (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.in_word    (fetch_word),
		.in_valid   (fetch_valid),
		.head_ready (head_ready),
		.in_ready   (fetch_ready),
		.head_word  (head_word),
		.head_valid (head_valid)
	);

	////////////////////////////////////////////////////////////////////
	// FPGA to host side
	////////////////////////////////////////////////////////////////////

	hps_fifo_issue u_issue (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.head_word  (head_word),
		.head_valid (head_valid),
		.sink_full  (sink_full),
		.head_ready (head_ready),
		.sink       (sink)
	);

endmodule

//--- verif/tb_fifo_loopback.sv
`include "loop_defs.svh"

module tb_fifo_loopback
	import loop_buf_pkg::*, hps_port_pkg::*;
();

	localparam int NUM_WORDS = 400;
	// Chance in percent of a source stall or a full sink
	localparam int STALL_PCT = 20;
	localparam int FULL_PCT  = 30;
	// Store plus fetch holding register plus issue register
	localparam int OCC_LIMIT = `LOOP_DEPTH + 2;

	logic       CLOCK_50;
	logic       rst_n;
	src_port_t  src;
	logic       sink_full;
	logic       src_read;
	sink_port_t sink;

	integer seed;

	// Words still in the source FIFO
	word_t src_q[$];
	// Words read but not yet seen at the sink in age order
	word_t exp_q[$];

	int read_cnt;
	int write_cnt;
	int max_occ;
	bit prev_read;
	bit prev_write;
	// Forces sink_full high for the long burst
	bit full_hold;
	bit timed_out;
	int data_errors;
	int proto_errors;
	int timeout_errors;

	fifo_loopback_top u_dut (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.src       (src),
		.sink_full (sink_full),
		.src_read  (src_read),
		.sink      (sink)
	);

	// Falling edge comes first so sampling sits mid cycle
	initial CLOCK_50 = 1'b1;
	always #5 CLOCK_50 = ~CLOCK_50;

	//////////////////////////////////////////////////////////////////////
	// Compare and report helpers
	//////////////////////////////////////////////////////////////////////

	function automatic bit roll_percent(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	task automatic check_word(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
		begin
			data_errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_count(input cnt_t actual, input cnt_t expected, input string what);
		if (actual !== expected)
		begin
			data_errors++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected)
		begin
			data_errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic flag_protocol(input string msg);
		proto_errors++;
		$display("Protocol error at time %0t: %s", $time, msg);
	endtask

	task automatic report_timeout(input string what, input int limit);
		timed_out = 1'b1;
		timeout_errors++;
		$display("Timeout at time %0t: %s did not happen within %0d cycles",
			$time, what, limit);
	endtask

	//////////////////////////////////////////////////////////////////////
	// One clock cycle of the source, sink and reference models
	//////////////////////////////////////////////////////////////////////

	task automatic step_cycle(input bit quiet);
		word_t resp;
		word_t want;
		bit    did_read;
		bit    did_write;
		int    occ;
		@(negedge CLOCK_50);
		did_read  = src_read;
		did_write = sink.write;
		// Junk on readdata unless a read is answered
		resp      = word_t'($random(seed));
		if (quiet)
		begin
			check_bit(src_read, 1'b0, "src_read around reset");
			check_bit(sink.write, 1'b0, "sink.write around reset");
		end
		// Source FIFO pops on the strobe
		if (did_read)
		begin
			if (src.empty)
				flag_protocol("src_read pulsed while src.empty was high");
			if (prev_read)
				flag_protocol("src_read pulsed in two adjacent cycles");
			if (src_q.size() > 0)
			begin
				resp = src_q.pop_front();
				exp_q.push_back(resp);
			end
			read_cnt++;
		end
		// Sink FIFO takes every write
		if (did_write)
		begin
			if (sink_full)
				flag_protocol("sink.write pulsed while sink_full was high");
			if (prev_write)
				flag_protocol("sink.write pulsed in two adjacent cycles");
			if (exp_q.size() == 0)
				flag_protocol("sink.write with no word outstanding");
			else
			begin
				want = exp_q.pop_front();
				check_word(sink.writedata, want, "sink.writedata");
			end
			write_cnt++;
		end
		prev_read  = did_read;
		prev_write = did_write;
		// Words inside the DUT
		occ = read_cnt - write_cnt;
		if (occ > max_occ)
			max_occ = occ;
		if (occ > OCC_LIMIT)
		begin
			data_errors++;
			$display("[FAIL] %0t occupancy %0d above limit %0d", $time, occ, OCC_LIMIT);
		end
		// Next cycle inputs just after the edge
		@(posedge CLOCK_50);
		#1;
		src.readdata = resp;
		// Source stays ready around reset so a stray strobe would show
		src.empty    = (src_q.size() == 0) || (!quiet && roll_percent(STALL_PCT));
		sink_full    = full_hold || roll_percent(FULL_PCT);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bounded waits
	//////////////////////////////////////////////////////////////////////

	task automatic wait_written(input int target, input int limit);
		int n;
		n = 0;
		while (!timed_out && write_cnt < target)
		begin
			step_cycle(1'b0);
			n++;
			if (n >= limit && write_cnt < target)
				report_timeout("sink writes reaching the target count", limit);
		end
	endtask

	// Reads quiet for a run of cycles
	task automatic wait_reads_stop(input int quiet_len, input int limit);
		int n;
		int idle;
		n    = 0;
		idle = 0;
		while (!timed_out && idle < quiet_len)
		begin
			step_cycle(1'b0);
			n++;
			idle = prev_read ? 0 : idle + 1;
			if (n >= limit && idle < quiet_len)
				report_timeout("src_read stopping under a full sink", limit);
		end
	endtask

	task automatic wait_read(input int limit);
		int n;
		bit seen;
		n    = 0;
		seen = 1'b0;
		while (!timed_out && !seen)
		begin
			step_cycle(1'b0);
			n++;
			seen = prev_read;
			if (!seen && n >= limit)
				report_timeout("src_read resuming after sink_full fell", limit);
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (!timed_out && (write_cnt < NUM_WORDS || exp_q.size() != 0))
		begin
			step_cycle(1'b0);
			n++;
			if (n >= limit && (write_cnt < NUM_WORDS || exp_q.size() != 0))
				report_timeout("all words reaching the sink", limit);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int i;
		seed           = 32'h0ede8880;
		read_cnt       = 0;
		write_cnt      = 0;
		max_occ        = 0;
		prev_read      = 1'b0;
		prev_write     = 1'b0;
		full_hold      = 1'b0;
		timed_out      = 1'b0;
		data_errors    = 0;
		proto_errors   = 0;
		timeout_errors = 0;
		for (i = 0; i < NUM_WORDS; i++)
			src_q.push_back(word_t'($random(seed)));
		// Source not empty so a strobe in reset would show
		rst_n        = 1'b0;
		src.readdata = '0;
		src.empty    = 1'b0;
		sink_full    = 1'b0;
		repeat (2) step_cycle(1'b1);
		rst_n = 1'b1;
		// First cycle out of reset
		step_cycle(1'b1);

		// Random stalls on both ports
		wait_written(100, 3000);

		// Long full burst fills the store and stops fetching
		full_hold = 1'b1;
		wait_reads_stop(60, 3000);
		if (!timed_out)
			check_count(cnt_t'(read_cnt - write_cnt - 2), cnt_t'(`LOOP_DEPTH),
				"store fill during full burst");
		full_hold = 1'b0;
		wait_read(100);

		// Drain the rest and watch for stray writes
		wait_drained(8000);
		if (!timed_out)
			repeat (20) step_cycle(1'b0);

		$display("Errors: data %0d, protocol %0d, timeout %0d (words %0d, peak occupancy %0d)",
			data_errors, proto_errors, timeout_errors, write_cnt, max_occ);
		if (data_errors + proto_errors + timeout_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
+incdir+rtl
rtl/loop_buf_pkg.sv
rtl/hps_port_pkg.sv
rtl/hps_fifo_fetch.sv
rtl/loop_store.sv
rtl/hps_fifo_issue.sv
rtl/fifo_loopback_top.sv
verif/tb_fifo_loopback.sv

//--- Makefile
# Verilator build and run of the FIFO loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_fifo_loopback
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
